//--- include/tile_defines.svh
/*
 * Tile network defines
 * Sizes shared by the on-tile request and response routers:
 * coordinate width, buffer depth, payload widths and port count.
 */

`ifndef TILE_DEFINES_SVH
`define TILE_DEFINES_SVH

// 8 tiles in a row
`define TILE_X_CORD_WIDTH 3

// Entries per router input buffer
`define TILE_FIFO_DEPTH 2

// Cache to directory request payload
`define TILE_REQ_DATA_WIDTH 32

// Directory to cache command payload
`define TILE_RESP_DATA_WIDTH 16

// West, east and local processor port
`define TILE_NUM_DIRS 3

`endif

//--- design/tile_pkg.sv
/*
 * Tile network package
 * Router port enumeration and the flit formats of the request
 * and response networks.
 */

`include "tile_defines.svh"

package tile_pkg;

   // Router ports, also the index of every per-port array
   typedef enum logic [1:0]
   {
      W = 2'd0,
      E = 2'd1,
      P = 2'd2
   } dir_e;

   // Destination stays the first field so any router can find it
   typedef struct packed
   {
      logic [`TILE_X_CORD_WIDTH-1:0]   dst_x;
      logic [`TILE_REQ_DATA_WIDTH-1:0] data;
   } req_flit_t;

   typedef struct packed
   {
      logic [`TILE_X_CORD_WIDTH-1:0]    dst_x;
      logic [`TILE_RESP_DATA_WIDTH-1:0] data;
   } resp_flit_t;

endpackage : tile_pkg

//--- design/mesh_fifo.sv
/*
 * Mesh input buffer
 * Small circular FIFO with valid/ready on both sides, holding
 * TILE_FIFO_DEPTH entries of any payload type.
 */

`timescale 1ns/10ps

`include "tile_defines.svh"

module mesh_fifo
#(
   parameter type payload_t = tile_pkg::req_flit_t
)
(
   input  logic     clk_i,
   input  logic     rst_n_i,

   input  payload_t in_data_i,
   input  logic     in_v_i,
   output logic     in_ready_o,

   output payload_t out_data_o,
   output logic     out_v_o,
   input  logic     out_ready_i
);

   localparam int DEPTH = `TILE_FIFO_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t           mem [DEPTH];
   logic [PTR_W-1:0]   wr_ptr_q;
   logic [PTR_W-1:0]   rd_ptr_q;
   logic [CNT_W-1:0]   count_q;
   logic               push;
   logic               pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   assign in_ready_o = (count_q != CNT_W'(DEPTH));
   assign out_v_o    = (count_q != '0);
   assign out_data_o = mem[rd_ptr_q];

   assign push = in_v_i && in_ready_o;
   assign pop  = out_v_o && out_ready_i;

   always_ff @(posedge clk_i)
   begin
      if (push)
         mem[wr_ptr_q] <= in_data_i;
   end

   // Push and pop may share a cycle
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr_q <= next_ptr(wr_ptr_q);
         if (pop)
            rd_ptr_q <= next_ptr(rd_ptr_q);
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule : mesh_fifo

//--- design/mesh_route_arbiter.sv
/*
 * Mesh output arbiter
 * Round-robin grant for one router output. The pointer is the
 * highest-priority input and holds the winner while it stalls.
 */

`timescale 1ns/10ps

`include "tile_defines.svh"

module mesh_route_arbiter
(
   input  logic                         clk_i,
   input  logic                         rst_n_i,

   input  logic [`TILE_NUM_DIRS-1:0]    req_i,
   output logic [`TILE_NUM_DIRS-1:0]    grant_o,

   output logic                         out_v_o,
   input  logic                         out_ready_i
);

   localparam int NUM_DIRS = `TILE_NUM_DIRS;

   tile_pkg::dir_e ptr_q;
   tile_pkg::dir_e winner;
   tile_pkg::dir_e winner_next;

   // First requester at or after the pointer
   always_comb
   begin
      int   idx;
      logic found;
      grant_o = '0;
      winner  = ptr_q;
      found   = 1'b0;
      for (int off = 0; off < NUM_DIRS; off++)
      begin
         idx = (int'(ptr_q) + off) % NUM_DIRS;
         if (!found && req_i[idx])
         begin
            found  = 1'b1;
            winner = tile_pkg::dir_e'(idx);
         end
      end
      if (found)
         grant_o[winner] = 1'b1;
   end

   assign out_v_o = |grant_o;

   assign winner_next = (winner == tile_pkg::P) ? tile_pkg::W
                                                : tile_pkg::dir_e'(winner + 2'd1);

   // A stalled winner becomes the pointer, so the grant cannot move
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         ptr_q <= tile_pkg::W;
      else if (out_v_o && out_ready_i)
         ptr_q <= winner_next;
      else if (out_v_o)
         ptr_q <= winner;
   end

endmodule : mesh_route_arbiter

//--- design/mesh_router.sv
/*
 * Buffered x-dimension mesh router
 * Three ports (west, east, local). Each input is buffered, its head
 * flit is routed by dst_x, and every output picks round-robin.
 */

`timescale 1ns/10ps

`include "tile_defines.svh"

module mesh_router
#(
   parameter type flit_t = tile_pkg::req_flit_t
)
(
   input  logic                                clk_i,
   input  logic                                rst_n_i,
   input  logic [`TILE_X_CORD_WIDTH-1:0]       my_x_i,

   input  flit_t [`TILE_NUM_DIRS-1:0]          in_data_i,
   input  logic  [`TILE_NUM_DIRS-1:0]          in_v_i,
   output logic  [`TILE_NUM_DIRS-1:0]          in_ready_o,

   output flit_t [`TILE_NUM_DIRS-1:0]          out_data_o,
   output logic  [`TILE_NUM_DIRS-1:0]          out_v_o,
   input  logic  [`TILE_NUM_DIRS-1:0]          out_ready_i
);

   localparam int NUM_DIRS = `TILE_NUM_DIRS;

   flit_t [NUM_DIRS-1:0]                 head_data;
   logic  [NUM_DIRS-1:0]                 head_v;
   logic  [NUM_DIRS-1:0]                 head_pop;

   // Indexed [output][input]
   logic  [NUM_DIRS-1:0][NUM_DIRS-1:0]   route_req;
   logic  [NUM_DIRS-1:0][NUM_DIRS-1:0]   grant;

   for (genvar i = 0; i < NUM_DIRS; i++)
   begin : g_in
      mesh_fifo
      #(
         .payload_t   (flit_t)
      )
      in_fifo
      (
         .clk_i       (clk_i),
         .rst_n_i     (rst_n_i),
         .in_data_i   (in_data_i[i]),
         .in_v_i      (in_v_i[i]),
         .in_ready_o  (in_ready_o[i]),
         .out_data_o  (head_data[i]),
         .out_v_o     (head_v[i]),
         .out_ready_i (head_pop[i])
      );
   end

   // X-only route decode of each head flit
   always_comb
   begin
      route_req = '0;
      for (int i = 0; i < NUM_DIRS; i++)
      begin
         if (head_v[i])
         begin
            if (head_data[i].dst_x < my_x_i)
               route_req[tile_pkg::W][i] = 1'b1;
            else if (head_data[i].dst_x > my_x_i)
               route_req[tile_pkg::E][i] = 1'b1;
            else
               route_req[tile_pkg::P][i] = 1'b1;
         end
      end
   end

   for (genvar o = 0; o < NUM_DIRS; o++)
   begin : g_out
      mesh_route_arbiter out_arb
      (
         .clk_i       (clk_i),
         .rst_n_i     (rst_n_i),
         .req_i       (route_req[o]),
         .grant_o     (grant[o]),
         .out_v_o     (out_v_o[o]),
         .out_ready_i (out_ready_i[o])
      );
   end

   // Crossbar
   always_comb
   begin
      out_data_o = '0;
      for (int o = 0; o < NUM_DIRS; o++)
      begin
         for (int i = 0; i < NUM_DIRS; i++)
         begin
            if (grant[o][i])
               out_data_o[o] = head_data[i];
         end
      end
   end

   // Head leaves when its granted output transfers
   always_comb
   begin
      head_pop = '0;
      for (int i = 0; i < NUM_DIRS; i++)
      begin
         for (int o = 0; o < NUM_DIRS; o++)
         begin
            if (grant[o][i] && out_ready_i[o])
               head_pop[i] = 1'b1;
         end
      end
   end

endmodule : mesh_router

//--- design/tile_net.sv
/*
 * Tile network fabric
 * Request and response routers of one tile. They share the clock,
 * reset and tile x coordinate, and carry independent traffic.
 */

`timescale 1ns/10ps

`include "tile_defines.svh"

module tile_net
(
   input  logic                                          clk_i,
   input  logic                                          rst_n_i,
   input  logic [`TILE_X_CORD_WIDTH-1:0]                 my_x_i,

   // Cache to directory requests
   input  tile_pkg::req_flit_t  [`TILE_NUM_DIRS-1:0]     req_in_data_i,
   input  logic                 [`TILE_NUM_DIRS-1:0]     req_in_v_i,
   output logic                 [`TILE_NUM_DIRS-1:0]     req_in_ready_o,

   output tile_pkg::req_flit_t  [`TILE_NUM_DIRS-1:0]     req_out_data_o,
   output logic                 [`TILE_NUM_DIRS-1:0]     req_out_v_o,
   input  logic                 [`TILE_NUM_DIRS-1:0]     req_out_ready_i,

   // Directory to cache commands
   input  tile_pkg::resp_flit_t [`TILE_NUM_DIRS-1:0]     resp_in_data_i,
   input  logic                 [`TILE_NUM_DIRS-1:0]     resp_in_v_i,
   output logic                 [`TILE_NUM_DIRS-1:0]     resp_in_ready_o,

   output tile_pkg::resp_flit_t [`TILE_NUM_DIRS-1:0]     resp_out_data_o,
   output logic                 [`TILE_NUM_DIRS-1:0]     resp_out_v_o,
   input  logic                 [`TILE_NUM_DIRS-1:0]     resp_out_ready_i
);

   mesh_router
   #(
      .flit_t      (tile_pkg::req_flit_t)
   )
   req_router
   (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .my_x_i      (my_x_i),

      .in_data_i   (req_in_data_i),
      .in_v_i      (req_in_v_i),
      .in_ready_o  (req_in_ready_o),

      .out_data_o  (req_out_data_o),
      .out_v_o     (req_out_v_o),
      .out_ready_i (req_out_ready_i)
   );

   // Narrower flits, same router
   mesh_router
   #(
      .flit_t      (tile_pkg::resp_flit_t)
   )
   resp_router
   (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .my_x_i      (my_x_i),

      .in_data_i   (resp_in_data_i),
      .in_v_i      (resp_in_v_i),
      .in_ready_o  (resp_in_ready_o),

      .out_data_o  (resp_out_data_o),
      .out_v_o     (resp_out_v_o),
      .out_ready_i (resp_out_ready_i)
   );

endmodule : tile_net

//--- bench/tile_net_checker.sv
/*
 * Tile network handshake checker
 * Concurrent assertions on the valid/ready links of both routers,
 * bound into the tile network top level.
 */

`timescale 1ns/10ps

`include "tile_defines.svh"

module tile_net_checker
(
   input  logic                                          clk_i,
   input  logic                                          rst_n_i,
   input  logic [`TILE_X_CORD_WIDTH-1:0]                 my_x_i,
   input  tile_pkg::req_flit_t  [`TILE_NUM_DIRS-1:0]     req_in_data_i,
   input  logic                 [`TILE_NUM_DIRS-1:0]     req_in_v_i,
   input  tile_pkg::req_flit_t  [`TILE_NUM_DIRS-1:0]     req_out_data_o,
   input  logic                 [`TILE_NUM_DIRS-1:0]     req_out_v_o,
   input  logic                 [`TILE_NUM_DIRS-1:0]     req_out_ready_i,
   input  tile_pkg::resp_flit_t [`TILE_NUM_DIRS-1:0]     resp_in_data_i,
   input  logic                 [`TILE_NUM_DIRS-1:0]     resp_in_v_i,
   input  tile_pkg::resp_flit_t [`TILE_NUM_DIRS-1:0]     resp_out_data_o,
   input  logic                 [`TILE_NUM_DIRS-1:0]     resp_out_v_o,
   input  logic                 [`TILE_NUM_DIRS-1:0]     resp_out_ready_i
);

   for (genvar o = 0; o < `TILE_NUM_DIRS; o++)
   begin : g_out
      // A stalled output keeps its flit
      assert property (@(posedge clk_i) disable iff (!rst_n_i)
         req_out_v_o[o] && !req_out_ready_i[o] |=>
            req_out_v_o[o] && $stable(req_out_data_o[o]))
         else $error("request output %0d dropped or changed a stalled flit", o);

      assert property (@(posedge clk_i) disable iff (!rst_n_i)
         resp_out_v_o[o] && !resp_out_ready_i[o] |=>
            resp_out_v_o[o] && $stable(resp_out_data_o[o]))
         else $error("response output %0d dropped or changed a stalled flit", o);
   end

   assert property (@(posedge clk_i)
      !rst_n_i |-> (req_out_v_o == '0) && (resp_out_v_o == '0))
      else $error("output valid raised during reset");

   // Local port only delivers flits for this tile
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      req_out_v_o[tile_pkg::P] |-> req_out_data_o[tile_pkg::P].dst_x == my_x_i)
      else $error("request flit for another tile left the local port");

   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      resp_out_v_o[tile_pkg::P] |-> resp_out_data_o[tile_pkg::P].dst_x == my_x_i)
      else $error("response flit for another tile left the local port");

   // Flits never turn back toward the side they came from
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (!req_in_v_i[tile_pkg::W] || req_in_data_i[tile_pkg::W].dst_x >= my_x_i) &&
      (!req_in_v_i[tile_pkg::E] || req_in_data_i[tile_pkg::E].dst_x <= my_x_i))
      else $error("request input flit targets its own arrival side");

   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (!resp_in_v_i[tile_pkg::W] || resp_in_data_i[tile_pkg::W].dst_x >= my_x_i) &&
      (!resp_in_v_i[tile_pkg::E] || resp_in_data_i[tile_pkg::E].dst_x <= my_x_i))
      else $error("response input flit targets its own arrival side");

endmodule : tile_net_checker

bind tile_net tile_net_checker chk_i
(
   .clk_i            (clk_i),
   .rst_n_i          (rst_n_i),
   .my_x_i           (my_x_i),
   .req_in_data_i    (req_in_data_i),
   .req_in_v_i       (req_in_v_i),
   .req_out_data_o   (req_out_data_o),
   .req_out_v_o      (req_out_v_o),
   .req_out_ready_i  (req_out_ready_i),
   .resp_in_data_i   (resp_in_data_i),
   .resp_in_v_i      (resp_in_v_i),
   .resp_out_data_o  (resp_out_data_o),
   .resp_out_v_o     (resp_out_v_o),
   .resp_out_ready_i (resp_out_ready_i)
);

//--- bench/tile_net_tb.sv
/*
 * Tile network testbench
 * Random traffic on both routers with back-pressure, checked
 * against per-source, per-output queues of expected flits.
 */

`timescale 1ns/10ps

`include "tile_defines.svh"

module tile_net_tb;

   localparam int           NUM_DIRS   = `TILE_NUM_DIRS;
   localparam logic [2:0]   MY_X       = 3'd3;
   localparam int           DRAIN_MAX  = 2000;

   logic                                      clk_i;
   logic                                      rst_n_i;
   logic [`TILE_X_CORD_WIDTH-1:0]             my_x_i;
   tile_pkg::req_flit_t  [NUM_DIRS-1:0]       req_in_data_i;
   logic                 [NUM_DIRS-1:0]       req_in_v_i;
   logic                 [NUM_DIRS-1:0]       req_in_ready_o;
   tile_pkg::req_flit_t  [NUM_DIRS-1:0]       req_out_data_o;
   logic                 [NUM_DIRS-1:0]       req_out_v_o;
   logic                 [NUM_DIRS-1:0]       req_out_ready_i;
   tile_pkg::resp_flit_t [NUM_DIRS-1:0]       resp_in_data_i;
   logic                 [NUM_DIRS-1:0]       resp_in_v_i;
   logic                 [NUM_DIRS-1:0]       resp_in_ready_o;
   tile_pkg::resp_flit_t [NUM_DIRS-1:0]       resp_out_data_o;
   logic                 [NUM_DIRS-1:0]       resp_out_v_o;
   logic                 [NUM_DIRS-1:0]       resp_out_ready_i;

   // Expected flits, indexed by source * NUM_DIRS + output
   logic [34:0]   req_q  [NUM_DIRS*NUM_DIRS][$];
   logic [18:0]   resp_q [NUM_DIRS*NUM_DIRS][$];

   logic [13:0]   req_seq  [NUM_DIRS];
   logic [13:0]   resp_seq [NUM_DIRS];
   int            req_rate;
   int            resp_rate;
   int            ready_rate;
   int            req_seen;
   int            resp_seen;

   tile_net dut_i
   (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .my_x_i           (my_x_i),
      .req_in_data_i    (req_in_data_i),
      .req_in_v_i       (req_in_v_i),
      .req_in_ready_o   (req_in_ready_o),
      .req_out_data_o   (req_out_data_o),
      .req_out_v_o      (req_out_v_o),
      .req_out_ready_i  (req_out_ready_i),
      .resp_in_data_i   (resp_in_data_i),
      .resp_in_v_i      (resp_in_v_i),
      .resp_in_ready_o  (resp_in_ready_o),
      .resp_out_data_o  (resp_out_data_o),
      .resp_out_v_o     (resp_out_v_o),
      .resp_out_ready_i (resp_out_ready_i)
   );

   always #4 clk_i = ~clk_i;

   task automatic compare_value(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
      if (exp !== act)
      begin
         $display("Error: %s expected %h actual %h", name, exp, act);
         $display("** FAIL **");
         $fatal(1);
      end
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("** FAIL **");
      $fatal(1);
   endtask

   // Senders never aim a flit back at the side it came from
   function automatic logic [2:0] pick_dst(input int src);
      if (src == tile_pkg::W)
         return MY_X + 3'($urandom_range(4, 0));
      if (src == tile_pkg::E)
         return 3'($urandom_range(3, 0));
      return 3'($urandom_range(7, 0));
   endfunction

   function automatic int route_of(input logic [2:0] dst);
      if (dst < MY_X)
         return tile_pkg::W;
      if (dst > MY_X)
         return tile_pkg::E;
      return tile_pkg::P;
   endfunction

   function automatic bit queues_empty();
      for (int k = 0; k < NUM_DIRS * NUM_DIRS; k++)
      begin
         if (req_q[k].size() != 0 || resp_q[k].size() != 0)
            return 1'b0;
      end
      return 1'b1;
   endfunction

   task automatic expect_req(input int o, input tile_pkg::req_flit_t act);
      int          src;
      logic [34:0] exp;
      src = int'(act.data[31:30]);
      if (src >= NUM_DIRS || req_q[src*NUM_DIRS+o].size() == 0)
         abort_run($sformatf("Unexpected request flit %h on output %0d", act, o));
      else
      begin
         exp = req_q[src*NUM_DIRS+o].pop_front();
         compare_value($sformatf("request out %0d from %0d", o, src), 64'(exp), 64'(act));
         req_seen++;
      end
   endtask

   task automatic expect_resp(input int o, input tile_pkg::resp_flit_t act);
      int          src;
      logic [18:0] exp;
      src = int'(act.data[15:14]);
      if (src >= NUM_DIRS || resp_q[src*NUM_DIRS+o].size() == 0)
         abort_run($sformatf("Unexpected response flit %h on output %0d", act, o));
      else
      begin
         exp = resp_q[src*NUM_DIRS+o].pop_front();
         compare_value($sformatf("response out %0d from %0d", o, src), 64'(exp), 64'(act));
         resp_seen++;
      end
   endtask

   // Monitor transfers of the past cycle, then drive the next one
   always @(posedge clk_i)
   begin
      tile_pkg::req_flit_t  rf;
      tile_pkg::resp_flit_t sf;
      if (rst_n_i)
      begin
         for (int o = 0; o < NUM_DIRS; o++)
         begin
            if (req_out_v_o[o] && req_out_ready_i[o])
               expect_req(o, req_out_data_o[o]);
            if (resp_out_v_o[o] && resp_out_ready_i[o])
               expect_resp(o, resp_out_data_o[o]);
            req_out_ready_i[o]  <= ($urandom_range(99, 0) < ready_rate);
            resp_out_ready_i[o] <= ($urandom_range(99, 0) < ready_rate);
         end
         for (int i = 0; i < NUM_DIRS; i++)
         begin
            if (req_in_v_i[i] && req_in_ready_o[i])
               req_q[i*NUM_DIRS+route_of(req_in_data_i[i].dst_x)].push_back(req_in_data_i[i]);
            if (resp_in_v_i[i] && resp_in_ready_o[i])
               resp_q[i*NUM_DIRS+route_of(resp_in_data_i[i].dst_x)].push_back(resp_in_data_i[i]);
            // A raised valid stays put until accepted
            if (!req_in_v_i[i] || req_in_ready_o[i])
            begin
               if ($urandom_range(99, 0) < req_rate)
               begin
                  rf.dst_x = pick_dst(i);
                  rf.data  = {2'(i), req_seq[i], 16'($urandom)};
                  req_seq[i] <= req_seq[i] + 1'b1;
                  req_in_data_i[i] <= rf;
                  req_in_v_i[i]    <= 1'b1;
               end
               else
                  req_in_v_i[i] <= 1'b0;
            end
            if (!resp_in_v_i[i] || resp_in_ready_o[i])
            begin
               if ($urandom_range(99, 0) < resp_rate)
               begin
                  sf.dst_x = pick_dst(i);
                  sf.data  = {2'(i), resp_seq[i]};
                  resp_seq[i] <= resp_seq[i] + 1'b1;
                  resp_in_data_i[i] <= sf;
                  resp_in_v_i[i]    <= 1'b1;
               end
               else
                  resp_in_v_i[i] <= 1'b0;
            end
         end
      end
   end

   task automatic set_load(input int rq, input int rs, input int rdy);
      @(negedge clk_i);
      req_rate   = rq;
      resp_rate  = rs;
      ready_rate = rdy;
   endtask

   task automatic drain_all();
      int cycles;
      set_load(0, 0, 100);
      cycles = 0;
      while (!(queues_empty() && req_in_v_i == '0 && resp_in_v_i == '0))
      begin
         @(posedge clk_i);
         cycles++;
         if (cycles > DRAIN_MAX)
            abort_run("Timeout: flits still in flight after the senders stopped");
      end
   endtask

   initial
   begin
      int resp_before;
      int req_before;
      void'($urandom(32'h1e742e99));
      clk_i = 1'b0;
      rst_n_i = 1'b0;
      my_x_i = MY_X;
      req_in_data_i = '0;
      req_in_v_i = '0;
      req_out_ready_i = '0;
      resp_in_data_i = '0;
      resp_in_v_i = '0;
      resp_out_ready_i = '0;
      req_rate = 0;
      resp_rate = 0;
      ready_rate = 0;
      req_seen = 0;
      resp_seen = 0;
      for (int i = 0; i < NUM_DIRS; i++)
      begin
         req_seq[i] = '0;
         resp_seq[i] = '0;
      end

      repeat (4) @(posedge clk_i);
      rst_n_i <= 1'b1;
      #1;
      compare_value("reset req out_v", 64'd0, 64'(req_out_v_o));
      compare_value("reset resp out_v", 64'd0, 64'(resp_out_v_o));
      compare_value("reset req in_ready", 64'h7, 64'(req_in_ready_o));
      compare_value("reset resp in_ready", 64'h7, 64'(resp_in_ready_o));

      // Mixed traffic with back-pressure
      set_load(60, 60, 60);
      repeat (1500) @(posedge clk_i);
      drain_all();

      // Saturated request network beside light responses
      resp_before = resp_seen;
      set_load(100, 20, 70);
      repeat (800) @(posedge clk_i);
      compare_value("responses under request load", 64'd1, 64'(resp_seen > resp_before));
      drain_all();

      req_before = req_seen;
      set_load(20, 100, 70);
      repeat (800) @(posedge clk_i);
      compare_value("requests under response load", 64'd1, 64'(req_seen > req_before));
      drain_all();

      $display("** PASS **");
      $finish;
   end

endmodule : tile_net_tb

//--- tile_net.f
+incdir+include
design/tile_pkg.sv
design/mesh_fifo.sv
design/mesh_route_arbiter.sv
design/mesh_router.sv
design/tile_net.sv
bench/tile_net_checker.sv
bench/tile_net_tb.sv

//--- Makefile
# Verilator build for the tile network testbench

VERILATOR ?= verilator
TOP       ?= tile_net_tb
FILELIST  ?= tile_net.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -sv -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST) | grep -v '^+') include/tile_defines.svh
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
